//--- all.f
mac_seg_pkg.sv
mfb_seg_decode.sv
mac_seg_framer.sv
tx_mac_lite_adapter_mac_seg.sv
testbench.sv

//--- Makefile
# Verilator flow for the MFB to MAC segment adapter

TOP = testbench

all: run

build:
	verilator --binary --assert --timing -j 0 --top-module $(TOP) -f all.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q '^\*\* PASS \*\*$$' sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- testbench.sv
// --------------------------------------
// testbench for the MFB to MAC adapter
// random frame generator, expected words,
// immediate assertions on the MAC side
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

module testbench
    import mac_seg_pkg::*;
;

    localparam int REGIONS     = 2;
    localparam int REGION_SIZE = 4;
    localparam int SEGMENTS    = REGIONS * REGION_SIZE;
    localparam int DW          = SEGMENTS * SEG_W;
    localparam int SOF_W       = $clog2(REGION_SIZE);
    localparam int EOF_W       = $clog2(REGION_SIZE * BLOCK_BYTES);
    localparam int NUM_WORDS   = 300;
    localparam int CLK_PERIOD  = 4;

    logic                       clk;
    logic                       rst;
    logic [DW-1:0]              in_mfb_data;
    logic [REGIONS-1:0]         in_mfb_sof;
    logic [REGIONS*SOF_W-1:0]   in_mfb_sof_pos;
    logic [REGIONS-1:0]         in_mfb_eof;
    logic [REGIONS*EOF_W-1:0]   in_mfb_eof_pos;
    logic [REGIONS-1:0]         in_mfb_error;
    logic                       in_mfb_src_rdy;
    logic                       in_mfb_dst_rdy;
    logic [DW-1:0]              out_mac_data;
    logic [SEGMENTS-1:0]        out_mac_inframe;
    logic [SEGMENTS*3-1:0]      out_mac_eop_empty;
    logic [SEGMENTS-1:0]        out_mac_error;
    logic                       out_mac_valid;
    logic                       out_mac_ready;

    // generated input words and the MAC words they should become
    logic [DW-1:0]              w_data    [NUM_WORDS];
    logic [REGIONS-1:0]         w_sof     [NUM_WORDS];
    logic [REGIONS*SOF_W-1:0]   w_sof_pos [NUM_WORDS];
    logic [REGIONS-1:0]         w_eof     [NUM_WORDS];
    logic [REGIONS*EOF_W-1:0]   w_eof_pos [NUM_WORDS];
    logic [REGIONS-1:0]         w_err     [NUM_WORDS];
    logic [SEGMENTS-1:0]        e_inframe [NUM_WORDS];
    logic [SEGMENTS*3-1:0]      e_empty   [NUM_WORDS];
    logic [SEGMENTS-1:0]        e_error   [NUM_WORDS];

    int          exp_q[$];     // accepted word indices in arrival order
    logic [15:0] lfsr = 16'd11400;
    int          sent = 0;
    int          taken = 0;
    int          checks = 0;
    int          errors = 0;
    int          idx;
    logic        first_cycle = 1'b0;
    logic        lat_chk = 1'b0;
    logic        hold_chk = 1'b0;
    logic [DW-1:0] hold_data;
    logic [39:0]   hold_flags;

    tx_mac_lite_adapter_mac_seg #(
        .REGIONS     (REGIONS),
        .REGION_SIZE (REGION_SIZE)
    ) i_dut (
        .clk               (clk),
        .rst               (rst),
        .in_mfb_data       (in_mfb_data),
        .in_mfb_sof        (in_mfb_sof),
        .in_mfb_sof_pos    (in_mfb_sof_pos),
        .in_mfb_eof        (in_mfb_eof),
        .in_mfb_eof_pos    (in_mfb_eof_pos),
        .in_mfb_error      (in_mfb_error),
        .in_mfb_src_rdy    (in_mfb_src_rdy),
        .in_mfb_dst_rdy    (in_mfb_dst_rdy),
        .out_mac_data      (out_mac_data),
        .out_mac_inframe   (out_mac_inframe),
        .out_mac_eop_empty (out_mac_eop_empty),
        .out_mac_error     (out_mac_error),
        .out_mac_valid     (out_mac_valid),
        .out_mac_ready     (out_mac_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois LFSR stepped once per returned bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s at %0t: expected %0h, actual %0h", name, $time, exp, act);
        end
    endtask

    // remain counts the bytes of the open frame still to place
    task automatic build_words();
        int remain;
        int r;
        int blk;
        remain = 0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            w_sof[w]     = '0;
            w_sof_pos[w] = '0;
            w_eof[w]     = '0;
            w_eof_pos[w] = '0;
            w_err[w]     = REGIONS'(rand_bits(REGIONS));   // ignored where no end
            e_inframe[w] = '0;
            e_empty[w]   = '0;
            e_error[w]   = '0;
            for (int s = 0; s < SEGMENTS; s++) begin
                r   = s / REGION_SIZE;
                blk = s % REGION_SIZE;
                w_data[w][s*SEG_W +: SEG_W] = rand_bits(SEG_W);
                if (remain == 0 && !w_sof[w][r] && rand_bits(2) != '0) begin
                    w_sof[w][r] = 1'b1;
                    w_sof_pos[w][r*SOF_W +: SOF_W] = SOF_W'(blk);
                    // region end already used so this frame must leave the region
                    if (w_eof[w][r])
                        remain = (REGION_SIZE - blk) * 8 + 1 + int'(rand_bits(5));
                    else
                        remain = 1 + int'(rand_bits(7));
                end
                if (remain > 0 && remain <= 8) begin
                    w_eof[w][r] = 1'b1;
                    w_eof_pos[w][r*EOF_W +: EOF_W] = EOF_W'(blk * 8 + remain - 1);
                    e_empty[w][s*3 +: 3] = 3'(8 - remain);
                    e_error[w][s] = w_err[w][r];
                    remain = 0;
                end else if (remain > 8) begin
                    e_inframe[w][s] = 1'b1;
                    remain = remain - 8;
                end
            end
        end
    endtask

    // checks read pre-edge values before the next input word is driven
    always @(posedge clk) begin
        if (rst) begin
            first_cycle = 1'b1;
            in_mfb_src_rdy <= 1'b0;
            out_mac_ready  <= 1'b0;
        end else begin
            if (first_cycle) begin
                check_val("valid after reset", '0, DW'(out_mac_valid));
                check_val("dst_rdy after reset", DW'(1'b1), DW'(in_mfb_dst_rdy));
            end
            first_cycle = 1'b0;
            if (lat_chk)
                check_val("one cycle latency", DW'(1'b1), DW'(out_mac_valid));
            if (hold_chk) begin
                check_val("hold data", hold_data, out_mac_data);
                check_val("hold flags", DW'(hold_flags),
                          DW'({out_mac_inframe, out_mac_eop_empty, out_mac_error}));
            end
            hold_chk = out_mac_valid && !out_mac_ready;
            if (hold_chk) begin
                hold_data  = out_mac_data;
                hold_flags = {out_mac_inframe, out_mac_eop_empty, out_mac_error};
                check_val("dst_rdy under back-pressure", '0, DW'(in_mfb_dst_rdy));
            end
            if (out_mac_valid && out_mac_ready) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("output word taken at %0t with no accepted input left", $time);
                end
                if (exp_q.size() > 0) begin
                    idx = exp_q.pop_front();
                    check_val("data", w_data[idx], out_mac_data);
                    check_val("inframe", DW'(e_inframe[idx]), DW'(out_mac_inframe));
                    check_val("eop_empty", DW'(e_empty[idx]), DW'(out_mac_eop_empty));
                    check_val("fcs_error", DW'(e_error[idx]), DW'(out_mac_error));
                    taken++;
                end
            end
            lat_chk = in_mfb_src_rdy && in_mfb_dst_rdy;
            if (lat_chk) begin
                exp_q.push_back(sent);
                sent++;
            end
            if (!in_mfb_src_rdy || lat_chk) begin
                if (sent < NUM_WORDS && rand_bits(2) != '0) begin
                    in_mfb_data    <= w_data[sent];
                    in_mfb_sof     <= w_sof[sent];
                    in_mfb_sof_pos <= w_sof_pos[sent];
                    in_mfb_eof     <= w_eof[sent];
                    in_mfb_eof_pos <= w_eof_pos[sent];
                    in_mfb_error   <= w_err[sent];
                    in_mfb_src_rdy <= 1'b1;
                end else begin
                    in_mfb_src_rdy <= 1'b0;
                end
            end
            out_mac_ready <= (rand_bits(2) != '0);   // ready low about a quarter of cycles
        end
    end

    initial begin
        #(NUM_WORDS * 8 * CLK_PERIOD + 400);
        $display("watchdog expired with %0d of %0d words taken", taken, NUM_WORDS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        in_mfb_data    = '0;
        in_mfb_sof     = '0;
        in_mfb_sof_pos = '0;
        in_mfb_eof     = '0;
        in_mfb_eof_pos = '0;
        in_mfb_error   = '0;
        in_mfb_src_rdy = 1'b0;
        out_mac_ready  = 1'b0;
        build_words();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait (taken == NUM_WORDS);
        repeat (8) @(posedge clk);   // catch any extra output word
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tx_mac_lite_adapter_mac_seg.sv
// --------------------------------------
// MFB to Intel MAC segment adapter top
// decoder and framer instances
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

module tx_mac_lite_adapter_mac_seg
    import mac_seg_pkg::*;
#(
    parameter int REGIONS     = 2,
    parameter int REGION_SIZE = 8,
    localparam int SEGMENTS   = REGIONS * REGION_SIZE,
    localparam int SOF_POS_W  = (REGION_SIZE > 1) ? $clog2(REGION_SIZE) : 1,
    localparam int EOF_POS_W  = $clog2(REGION_SIZE * BLOCK_BYTES)
) (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // MFB input
    input  wire logic [SEGMENTS*SEG_W-1:0]     in_mfb_data,
    input  wire logic [REGIONS-1:0]            in_mfb_sof,
    input  wire logic [REGIONS*SOF_POS_W-1:0]  in_mfb_sof_pos,
    input  wire logic [REGIONS-1:0]            in_mfb_eof,
    input  wire logic [REGIONS*EOF_POS_W-1:0]  in_mfb_eof_pos,
    input  wire logic [REGIONS-1:0]            in_mfb_error,
    input  wire logic                          in_mfb_src_rdy,
    output logic                               in_mfb_dst_rdy,

    // MAC segmented output
    output seg_data_t  [SEGMENTS-1:0]          out_mac_data,
    output logic       [SEGMENTS-1:0]          out_mac_inframe,
    output seg_empty_t [SEGMENTS-1:0]          out_mac_eop_empty,
    output logic       [SEGMENTS-1:0]          out_mac_error,
    output logic                               out_mac_valid,
    input  wire logic                          out_mac_ready
);

    seg_data_t [SEGMENTS-1:0] seg_data;
    logic      [SEGMENTS-1:0] seg_sop;
    logic      [SEGMENTS-1:0] seg_eop;
    seg_byte_t [SEGMENTS-1:0] seg_eop_byte;
    logic      [SEGMENTS-1:0] seg_error;

    mfb_seg_decode #(
        .REGIONS     (REGIONS),
        .REGION_SIZE (REGION_SIZE)
    ) u_decode (
        .in_data      (in_mfb_data),
        .sof          (in_mfb_sof),
        .sof_pos      (in_mfb_sof_pos),
        .eof          (in_mfb_eof),
        .eof_pos      (in_mfb_eof_pos),
        .error        (in_mfb_error),
        .seg_data     (seg_data),
        .seg_sop      (seg_sop),
        .seg_eop      (seg_eop),
        .seg_eop_byte (seg_eop_byte),
        .seg_error    (seg_error)
    );

    mac_seg_framer #(
        .REGIONS     (REGIONS),
        .REGION_SIZE (REGION_SIZE)
    ) u_framer (
        .clk           (clk),
        .rst           (rst),
        .seg_data      (seg_data),
        .seg_sop       (seg_sop),
        .seg_eop       (seg_eop),
        .seg_eop_byte  (seg_eop_byte),
        .seg_error     (seg_error),
        .src_rdy       (in_mfb_src_rdy),
        .dst_rdy       (in_mfb_dst_rdy),
        .mac_data      (out_mac_data),
        .mac_inframe   (out_mac_inframe),
        .mac_eop_empty (out_mac_eop_empty),
        .mac_error     (out_mac_error),
        .valid         (out_mac_valid),
        .ready         (out_mac_ready)
    );

endmodule

`default_nettype wire

//--- mac_seg_framer.sv
// --------------------------------------
// MAC segment framer
// inframe / eop_empty / fcs_error per
// segment, output register with ready
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

module mac_seg_framer
    import mac_seg_pkg::*;
#(
    parameter int REGIONS     = 2,
    parameter int REGION_SIZE = 8,
    localparam int SEGMENTS   = REGIONS * REGION_SIZE
) (
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire seg_data_t [SEGMENTS-1:0] seg_data,
    input  wire logic   [SEGMENTS-1:0]    seg_sop,
    input  wire logic   [SEGMENTS-1:0]    seg_eop,
    input  wire seg_byte_t [SEGMENTS-1:0] seg_eop_byte,
    input  wire logic   [SEGMENTS-1:0]    seg_error,
    input  wire logic                     src_rdy,
    output logic                          dst_rdy,

    output seg_data_t   [SEGMENTS-1:0]    mac_data,
    output logic        [SEGMENTS-1:0]    mac_inframe,
    output seg_empty_t  [SEGMENTS-1:0]    mac_eop_empty,
    output logic        [SEGMENTS-1:0]    mac_error,
    output logic                          valid,
    input  wire logic                     ready
);

    framer_state_t              state_q;     // open state after last accepted word
    framer_state_t              state_next;
    logic        [SEGMENTS-1:0] inframe_d;
    seg_empty_t  [SEGMENTS-1:0] empty_d;
    logic        [SEGMENTS-1:0] error_d;
    logic                       accept;

    // output slot is free or being emptied this cycle
    assign dst_rdy = !valid || ready;
    assign accept  = src_rdy && dst_rdy;

    // frame state ripples through the segments in order
    always_comb begin
        framer_state_t st;
        logic          open;

        st = state_q;
        for (int s = 0; s < SEGMENTS; s++) begin
            open = (st == in_frame) || seg_sop[s];

            inframe_d[s] = open && !seg_eop[s];
            if (seg_eop[s]) begin
                empty_d[s] = seg_empty_t'(3'd7 - seg_eop_byte[s]);
            end else begin
                empty_d[s] = '0;
            end
            error_d[s] = seg_eop[s] & seg_error[s];

            // an ending segment closes the frame
            st = inframe_d[s] ? in_frame : idle;
        end
        state_next = st;
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= 1'b0;
            state_q <= idle;
        end else begin
            if (accept) begin
                valid   <= 1'b1;
                state_q <= state_next;
            end else if (ready) begin
                valid <= 1'b0;    // word taken with nothing new behind it
            end
        end
    end

    // output word loads only on accept and holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            mac_data      <= seg_data;
            mac_inframe   <= inframe_d;
            mac_eop_empty <= empty_d;
            mac_error     <= error_d;
        end
    end

endmodule

`default_nettype wire

//--- mfb_seg_decode.sv
// --------------------------------------
// MFB position decoder
// per-region sof/eof positions expanded
// into per-segment start and end flags
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

module mfb_seg_decode
    import mac_seg_pkg::*;
#(
    parameter int REGIONS     = 2,
    parameter int REGION_SIZE = 8,
    localparam int SEGMENTS   = REGIONS * REGION_SIZE,
    localparam int SOF_POS_W  = (REGION_SIZE > 1) ? $clog2(REGION_SIZE) : 1,
    localparam int EOF_POS_W  = $clog2(REGION_SIZE * BLOCK_BYTES)
) (
    input  wire logic [SEGMENTS*SEG_W-1:0]     in_data,
    input  wire logic [REGIONS-1:0]            sof,
    input  wire logic [REGIONS*SOF_POS_W-1:0]  sof_pos,
    input  wire logic [REGIONS-1:0]            eof,
    input  wire logic [REGIONS*EOF_POS_W-1:0]  eof_pos,
    input  wire logic [REGIONS-1:0]            error,

    output seg_data_t  [SEGMENTS-1:0]          seg_data,
    output logic       [SEGMENTS-1:0]          seg_sop,
    output logic       [SEGMENTS-1:0]          seg_eop,
    output seg_byte_t  [SEGMENTS-1:0]          seg_eop_byte,
    output logic       [SEGMENTS-1:0]          seg_error
);

    // payload is not touched, blocks and segments line up one to one
    assign seg_data = in_data;

    for (genvar s = 0; s < SEGMENTS; s++) begin : g_seg
        localparam int REG = s / REGION_SIZE;   // owning region
        localparam int BLK = s % REGION_SIZE;   // block inside region

        logic [SOF_POS_W-1:0] sof_pos_r;
        logic [EOF_POS_W-1:0] eof_pos_r;
        logic                 eop_hit;

        assign sof_pos_r = sof_pos[REG*SOF_POS_W +: SOF_POS_W];
        assign eof_pos_r = eof_pos[REG*EOF_POS_W +: EOF_POS_W];

        // start is given as block index
        assign seg_sop[s] = sof[REG] && (sof_pos_r == SOF_POS_W'(BLK));

        // end is a byte index, upper bits select the block
        assign eop_hit    = eof[REG] && ((eof_pos_r >> 3) == EOF_POS_W'(BLK));
        assign seg_eop[s] = eop_hit;

        // low three bits give the last valid byte in the segment
        assign seg_eop_byte[s] = eop_hit ? seg_byte_t'(eof_pos_r[2:0]) : '0;

        // region error belongs to the frame ending there
        assign seg_error[s] = eop_hit & error[REG];
    end

endmodule

`default_nettype wire

//--- mac_seg_pkg.sv
// --------------------------------------
// block geometry shared by MFB and MAC
// segment typedefs and framer state enum
// --------------------------------------

`default_nettype none

package mac_seg_pkg;

    // one MFB block maps onto one MAC segment
    localparam int BLOCK_BYTES = 8;
    localparam int BYTE_W      = 8;
    localparam int SEG_W       = BLOCK_BYTES * BYTE_W;   // 64 bits

    // one segment of payload
    typedef logic [SEG_W-1:0] seg_data_t;

    // unused bytes in an ending segment
    typedef logic [2:0] seg_empty_t;

    // byte index inside a segment
    typedef logic [2:0] seg_byte_t;

    // frame open or not, carried across segments and words
    typedef enum logic {
        idle,
        in_frame
    } framer_state_t;

endpackage

`default_nettype wire
